/* rtl/axi_burst_pkg.sv */
package axi_burst_pkg;

   localparam int ADDR_W    = 32;
   localparam int DATA_W    = 32;
   localparam int STRB_W    = DATA_W / 8;
   localparam int ID_W      = 4;
   localparam int LEN_W     = 4;
   localparam int MEM_WORDS = 256;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [DATA_W-1:0] data_t;
   typedef logic [STRB_W-1:0] strb_t;
   typedef logic [ID_W-1:0]   id_t;
   typedef logic [LEN_W-1:0]  len_t;
   typedef logic [2:0]        size_t;
   typedef logic [1:0]        burst_t;
   typedef logic [1:0]        resp_t;

   // code 3 is reserved and runs as incr
   localparam burst_t BURST_FIXED = 2'd0;
   localparam burst_t BURST_INCR  = 2'd1;
   localparam burst_t BURST_WRAP  = 2'd2;

   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_SLVERR = 2'd2;

endpackage

/* rtl/burst_addr_gen.sv */
module burst_addr_gen #(
   parameter axi_burst_pkg::addr_t BASE_ADDR = 32'h0000_0000,
   parameter axi_burst_pkg::addr_t HIGH_ADDR = 32'h0000_02FF
) (
   input  logic                  ACLK,
   input  logic                  ARESETN,
   input  logic                  load,
   input  axi_burst_pkg::addr_t  start_addr,
   input  axi_burst_pkg::len_t   len,
   input  axi_burst_pkg::size_t  size,
   input  axi_burst_pkg::burst_t burst,
   input  logic                  advance,
   output axi_burst_pkg::addr_t  addr,
   output logic                  last,
   output logic                  addr_ok
);

   logic [1:0]           size_c;
   logic                 wrap_len;
   axi_burst_pkg::addr_t ld_step;
   axi_burst_pkg::addr_t ld_span;
   axi_burst_pkg::addr_t ld_mask;
   axi_burst_pkg::addr_t step;
   axi_burst_pkg::addr_t wrap_base;
   axi_burst_pkg::addr_t wrap_mask;
   axi_burst_pkg::len_t  cnt;

   // fixed uses a zero step, incr an all-ones mask
   always_comb
   begin
      size_c   = (size > 3'd2) ? 2'd2 : size[1:0];
      wrap_len = (len == 4'd1) || (len == 4'd3) || (len == 4'd7) || (len == 4'd15);
      ld_span  = (axi_burst_pkg::addr_t'(len) + 1'b1) << size_c;
      ld_step  = (burst == axi_burst_pkg::BURST_FIXED) ? '0 : axi_burst_pkg::addr_t'(1) << size_c;
      ld_mask  = (burst == axi_burst_pkg::BURST_WRAP && wrap_len) ? ld_span - 1'b1 : '1;
   end

   always_ff @(posedge ACLK)
   begin
      if (!ARESETN)
         cnt <= '0;
      else if (load)
         cnt <= len;
      else if (advance && cnt != '0)
         cnt <= cnt - 1'b1;
   end

   always_ff @(posedge ACLK)
   begin
      if (load)
      begin
         addr      <= start_addr;
         step      <= ld_step;
         wrap_mask <= ld_mask;
         wrap_base <= start_addr & ~ld_mask;
      end
      else if (advance)
         addr <= wrap_base | ((addr + step) & wrap_mask);
   end

   assign last    = (cnt == '0);
   assign addr_ok = (addr >= BASE_ADDR) && (addr <= HIGH_ADDR);

endmodule

/* rtl/word_mem.sv */
module word_mem #(
   parameter int DEPTH = 256
) (
   input  logic                     ACLK,
   input  logic                     we,
   input  logic [$clog2(DEPTH)-1:0] windex,
   input  axi_burst_pkg::data_t     wdata,
   input  axi_burst_pkg::strb_t     wstrb,
   input  logic [$clog2(DEPTH)-1:0] rindex,
   output axi_burst_pkg::data_t     rdata
);

   axi_burst_pkg::data_t mem [DEPTH];

   // byte lanes
   always_ff @(posedge ACLK)
   begin
      if (we)
      begin
         for (int b = 0; b < axi_burst_pkg::STRB_W; b++)
         begin
            if (wstrb[b])
               mem[windex][8*b +: 8] <= wdata[8*b +: 8];
         end
      end
   end

   assign rdata = mem[rindex];

endmodule

/* rtl/axi_write_ctrl.sv */
module axi_write_ctrl #(
   parameter axi_burst_pkg::addr_t BASE_ADDR = 32'h0000_0000,
   parameter axi_burst_pkg::addr_t HIGH_ADDR = 32'h0000_02FF
) (
   input  logic                  ACLK,
   input  logic                  ARESETN,
   input  axi_burst_pkg::id_t    awid,
   input  axi_burst_pkg::addr_t  awaddr,
   input  axi_burst_pkg::len_t   awlen,
   input  axi_burst_pkg::size_t  awsize,
   input  axi_burst_pkg::burst_t awburst,
   input  logic                  awvalid,
   output logic                  awready,
   input  axi_burst_pkg::data_t  wdata,
   input  axi_burst_pkg::strb_t  wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   output axi_burst_pkg::id_t    bid,
   output axi_burst_pkg::resp_t  bresp,
   output logic                  bvalid,
   input  logic                  bready,
   output logic                  mem_we,
   output logic [$clog2(axi_burst_pkg::MEM_WORDS)-1:0] mem_windex,
   output axi_burst_pkg::data_t  mem_wdata,
   output axi_burst_pkg::strb_t  mem_wstrb
);

   localparam int IDX_W = $clog2(axi_burst_pkg::MEM_WORDS);

   localparam logic [1:0] ST_ADDR = 2'd0;
   localparam logic [1:0] ST_DATA = 2'd1;
   localparam logic [1:0] ST_RESP = 2'd2;

   logic [1:0]           state;
   logic                 err;
   logic                 aw_fire;
   logic                 w_fire;
   axi_burst_pkg::addr_t gen_addr;
   logic                 gen_last;
   logic                 gen_ok;

   assign aw_fire = awvalid && awready;
   assign w_fire  = wvalid && wready;

   burst_addr_gen #(
      .BASE_ADDR (BASE_ADDR),
      .HIGH_ADDR (HIGH_ADDR)
   ) i_burst_addr_gen (
      .ACLK       (ACLK),
      .ARESETN    (ARESETN),
      .load       (aw_fire),
      .start_addr (awaddr),
      .len        (awlen),
      .size       (awsize),
      .burst      (awburst),
      .advance    (w_fire),
      .addr       (gen_addr),
      .last       (gen_last),
      .addr_ok    (gen_ok)
   );

   always_ff @(posedge ACLK)
   begin
      if (!ARESETN)
      begin
         state   <= ST_ADDR;
         awready <= 1'b0;
         wready  <= 1'b0;
         bvalid  <= 1'b0;
         err     <= 1'b0;
      end
      else
      begin
         case (state)
            ST_ADDR:
            begin
               awready <= 1'b1;
               if (aw_fire)
               begin
                  awready <= 1'b0;
                  wready  <= 1'b1;
                  err     <= 1'b0;
                  state   <= ST_DATA;
               end
            end
            ST_DATA:
            begin
               if (w_fire)
               begin
                  if (!gen_ok)
                     err <= 1'b1;
                  // beat count ends the burst
                  if (gen_last)
                  begin
                     wready <= 1'b0;
                     bvalid <= 1'b1;
                     state  <= ST_RESP;
                  end
               end
            end
            default:
            begin
               if (bready)
               begin
                  bvalid  <= 1'b0;
                  awready <= 1'b1;
                  state   <= ST_ADDR;
               end
            end
         endcase
      end
   end

   always_ff @(posedge ACLK)
   begin
      if (aw_fire)
         bid <= awid;
   end

   assign bresp = err ? axi_burst_pkg::RESP_SLVERR : axi_burst_pkg::RESP_OKAY;

   // out-of-window beats are dropped
   assign mem_we     = w_fire && gen_ok;
   assign mem_windex = gen_addr[IDX_W+1:2];
   assign mem_wdata  = wdata;
   assign mem_wstrb  = wstrb;

endmodule

/* rtl/axi_read_ctrl.sv */
module axi_read_ctrl #(
   parameter axi_burst_pkg::addr_t BASE_ADDR = 32'h0000_0000,
   parameter axi_burst_pkg::addr_t HIGH_ADDR = 32'h0000_02FF
) (
   input  logic                  ACLK,
   input  logic                  ARESETN,
   input  axi_burst_pkg::id_t    arid,
   input  axi_burst_pkg::addr_t  araddr,
   input  axi_burst_pkg::len_t   arlen,
   input  axi_burst_pkg::size_t  arsize,
   input  axi_burst_pkg::burst_t arburst,
   input  logic                  arvalid,
   output logic                  arready,
   output axi_burst_pkg::id_t    rid,
   output axi_burst_pkg::data_t  rdata,
   output axi_burst_pkg::resp_t  rresp,
   output logic                  rlast,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [$clog2(axi_burst_pkg::MEM_WORDS)-1:0] mem_rindex,
   input  axi_burst_pkg::data_t  mem_rdata
);

   localparam int IDX_W = $clog2(axi_burst_pkg::MEM_WORDS);

   localparam logic [1:0] ST_ADDR    = 2'd0;
   localparam logic [1:0] ST_FETCH   = 2'd1;
   localparam logic [1:0] ST_PRESENT = 2'd2;

   logic [1:0]           state;
   logic                 ar_fire;
   logic                 r_fire;
   axi_burst_pkg::addr_t gen_addr;
   logic                 gen_last;
   logic                 gen_ok;

   assign ar_fire = arvalid && arready;
   assign r_fire  = rvalid && rready;

   burst_addr_gen #(
      .BASE_ADDR (BASE_ADDR),
      .HIGH_ADDR (HIGH_ADDR)
   ) i_burst_addr_gen (
      .ACLK       (ACLK),
      .ARESETN    (ARESETN),
      .load       (ar_fire),
      .start_addr (araddr),
      .len        (arlen),
      .size       (arsize),
      .burst      (arburst),
      .advance    (r_fire),
      .addr       (gen_addr),
      .last       (gen_last),
      .addr_ok    (gen_ok)
   );

   always_ff @(posedge ACLK)
   begin
      if (!ARESETN)
      begin
         state   <= ST_ADDR;
         arready <= 1'b0;
         rvalid  <= 1'b0;
         rlast   <= 1'b0;
      end
      else
      begin
         case (state)
            ST_ADDR:
            begin
               arready <= 1'b1;
               if (ar_fire)
               begin
                  arready <= 1'b0;
                  state   <= ST_FETCH;
               end
            end
            ST_FETCH:
            begin
               rvalid <= 1'b1;
               rlast  <= gen_last;
               state  <= ST_PRESENT;
            end
            default:
            begin
               if (r_fire)
               begin
                  rvalid <= 1'b0;
                  rlast  <= 1'b0;
                  if (rlast)
                  begin
                     arready <= 1'b1;
                     state   <= ST_ADDR;
                  end
                  else
                     state <= ST_FETCH;
               end
            end
         endcase
      end
   end

   // beat payload held through the present state
   always_ff @(posedge ACLK)
   begin
      if (ar_fire)
         rid <= arid;
      if (state == ST_FETCH)
      begin
         rdata <= gen_ok ? mem_rdata : '0;
         rresp <= gen_ok ? axi_burst_pkg::RESP_OKAY : axi_burst_pkg::RESP_SLVERR;
      end
   end

   assign mem_rindex = gen_addr[IDX_W+1:2];

endmodule

/* rtl/axi_burst_slave.sv */
module axi_burst_slave #(
   parameter axi_burst_pkg::addr_t BASE_ADDR = 32'h0000_0000,
   parameter axi_burst_pkg::addr_t HIGH_ADDR = 32'h0000_02FF
) (
   input  logic                  ACLK,
   input  logic                  ARESETN,
   input  axi_burst_pkg::id_t    awid,
   input  axi_burst_pkg::addr_t  awaddr,
   input  axi_burst_pkg::len_t   awlen,
   input  axi_burst_pkg::size_t  awsize,
   input  axi_burst_pkg::burst_t awburst,
   input  logic                  awvalid,
   output logic                  awready,
   input  axi_burst_pkg::data_t  wdata,
   input  axi_burst_pkg::strb_t  wstrb,
   input  logic                  wlast,
   input  logic                  wvalid,
   output logic                  wready,
   output axi_burst_pkg::id_t    bid,
   output axi_burst_pkg::resp_t  bresp,
   output logic                  bvalid,
   input  logic                  bready,
   input  axi_burst_pkg::id_t    arid,
   input  axi_burst_pkg::addr_t  araddr,
   input  axi_burst_pkg::len_t   arlen,
   input  axi_burst_pkg::size_t  arsize,
   input  axi_burst_pkg::burst_t arburst,
   input  logic                  arvalid,
   output logic                  arready,
   output axi_burst_pkg::id_t    rid,
   output axi_burst_pkg::data_t  rdata,
   output axi_burst_pkg::resp_t  rresp,
   output logic                  rlast,
   output logic                  rvalid,
   input  logic                  rready
);

   localparam int IDX_W = $clog2(axi_burst_pkg::MEM_WORDS);

   logic                 mem_we;
   logic [IDX_W-1:0]     mem_windex;
   axi_burst_pkg::data_t mem_wdata;
   axi_burst_pkg::strb_t mem_wstrb;
   logic [IDX_W-1:0]     mem_rindex;
   axi_burst_pkg::data_t mem_rdata;

   // the beat count ends a write burst
   axi_write_ctrl #(
      .BASE_ADDR (BASE_ADDR),
      .HIGH_ADDR (HIGH_ADDR)
   ) i_axi_write_ctrl (
      .ACLK       (ACLK),
      .ARESETN    (ARESETN),
      .awid       (awid),
      .awaddr     (awaddr),
      .awlen      (awlen),
      .awsize     (awsize),
      .awburst    (awburst),
      .awvalid    (awvalid),
      .awready    (awready),
      .wdata      (wdata),
      .wstrb      (wstrb),
      .wvalid     (wvalid),
      .wready     (wready),
      .bid        (bid),
      .bresp      (bresp),
      .bvalid     (bvalid),
      .bready     (bready),
      .mem_we     (mem_we),
      .mem_windex (mem_windex),
      .mem_wdata  (mem_wdata),
      .mem_wstrb  (mem_wstrb)
   );

   axi_read_ctrl #(
      .BASE_ADDR (BASE_ADDR),
      .HIGH_ADDR (HIGH_ADDR)
   ) i_axi_read_ctrl (
      .ACLK       (ACLK),
      .ARESETN    (ARESETN),
      .arid       (arid),
      .araddr     (araddr),
      .arlen      (arlen),
      .arsize     (arsize),
      .arburst    (arburst),
      .arvalid    (arvalid),
      .arready    (arready),
      .rid        (rid),
      .rdata      (rdata),
      .rresp      (rresp),
      .rlast      (rlast),
      .rvalid     (rvalid),
      .rready     (rready),
      .mem_rindex (mem_rindex),
      .mem_rdata  (mem_rdata)
   );

   word_mem #(
      .DEPTH (axi_burst_pkg::MEM_WORDS)
   ) i_word_mem (
      .ACLK   (ACLK),
      .we     (mem_we),
      .windex (mem_windex),
      .wdata  (mem_wdata),
      .wstrb  (mem_wstrb),
      .rindex (mem_rindex),
      .rdata  (mem_rdata)
   );

endmodule

/* bench/axi_burst_slave_assert.sv */
module axi_burst_slave_assert (
   input logic                 ACLK,
   input logic                 ARESETN,
   input logic                 awready,
   input logic                 wready,
   input logic                 wvalid,
   input logic                 wlast,
   input logic                 bvalid,
   input logic                 bready,
   input axi_burst_pkg::resp_t bresp,
   input logic                 rvalid,
   input logic                 rready,
   input logic                 rlast,
   input axi_burst_pkg::data_t rdata
);

   b_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
      bvalid && !bready |=> bvalid && $stable(bresp))
      else $error("bvalid or bresp changed before bready");

   r_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
      else $error("rvalid, rdata or rlast changed before rready");

   aw_w_excl: assert property (@(posedge ACLK) disable iff (!ARESETN)
      !(awready && wready))
      else $error("awready and wready high together");

   rlast_valid: assert property (@(posedge ACLK) disable iff (!ARESETN)
      rlast |-> rvalid)
      else $error("rlast without rvalid");

   // bvalid follows only the counted final beat
   wlast_count: assert property (@(posedge ACLK) disable iff (!ARESETN)
      wvalid && wready |=> (bvalid == $past(wlast)))
      else $error("wlast disagrees with the beat count");

endmodule

bind axi_burst_slave axi_burst_slave_assert i_axi_burst_slave_assert (.*);

/* bench/tb_axi_burst_slave.sv */
module tb_axi_burst_slave;

   localparam axi_burst_pkg::addr_t BASE = 32'h0000_0000;
   localparam axi_burst_pkg::addr_t HIGH = 32'h0000_02FF;
   localparam int RESET_CYCLES = 16;
   localparam int TXNS         = 300;
   localparam int FILL_BURSTS  = 12;
   localparam int LIMIT        = TXNS * 80 + RESET_CYCLES;
   localparam logic [31:0] SEED = 32'hbc541b59;

   logic ACLK = 1'b0;
   logic ARESETN;
   axi_burst_pkg::id_t    awid, bid, arid, rid;
   axi_burst_pkg::addr_t  awaddr, araddr;
   axi_burst_pkg::len_t   awlen, arlen;
   axi_burst_pkg::size_t  awsize, arsize;
   axi_burst_pkg::burst_t awburst, arburst;
   axi_burst_pkg::data_t  wdata, rdata;
   axi_burst_pkg::strb_t  wstrb;
   axi_burst_pkg::resp_t  bresp, rresp;
   logic awvalid, awready, wlast, wvalid, wready, bvalid, bready;
   logic arvalid, arready, rlast, rvalid, rready;

   axi_burst_pkg::data_t model [axi_burst_pkg::MEM_WORDS];
   axi_burst_pkg::addr_t beat_addr [16];
   int errors = 0;
   int checks = 0;
   int cycles = 0;

   axi_burst_slave #(
      .BASE_ADDR (BASE),
      .HIGH_ADDR (HIGH)
   ) i_axi_burst_slave (.*);

   always #5 ACLK = ~ACLK;

   always @(posedge ACLK)
   begin
      cycles = cycles + 1;
      if (cycles >= LIMIT)
      begin
         errors++;
         $display("timeout: the bursts did not complete within %0d cycles, errors: %0d",
                  LIMIT, errors);
         $display("TESTS FAILED");
         $finish;
      end
   end

   task automatic wait_cycle;
      @(posedge ACLK);
      #1;
   endtask

   task automatic check_data(string what, axi_burst_pkg::data_t got, axi_burst_pkg::data_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_resp(string what, axi_burst_pkg::resp_t got, axi_burst_pkg::resp_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_id(string what, axi_burst_pkg::id_t got, axi_burst_pkg::id_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_last(string what, logic got, logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(string what, logic got, logic exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   function automatic logic in_window(axi_burst_pkg::addr_t a);
      return (a >= BASE) && (a <= HIGH);
   endfunction

   function automatic axi_burst_pkg::data_t fill_word(axi_burst_pkg::addr_t a);
      return (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
   endfunction

   // expected beat addresses of one burst
   function automatic void compute_beat_addrs(axi_burst_pkg::addr_t start,
                                              axi_burst_pkg::len_t len,
                                              axi_burst_pkg::size_t size,
                                              axi_burst_pkg::burst_t burst);
      axi_burst_pkg::size_t sz;
      axi_burst_pkg::addr_t step;
      axi_burst_pkg::addr_t span;
      axi_burst_pkg::addr_t base;
      axi_burst_pkg::addr_t a;
      int beats;
      beats = int'(len) + 1;
      sz    = (size > 3'd2) ? 3'd2 : size;
      step  = axi_burst_pkg::addr_t'(1) << sz;
      span  = step * (axi_burst_pkg::addr_t'(len) + 32'd1);
      base  = start - (start % span);
      a     = start;
      for (int k = 0; k < beats; k++)
      begin
         beat_addr[k] = a;
         if (burst == axi_burst_pkg::BURST_FIXED)
            a = start;
         else if (burst == axi_burst_pkg::BURST_WRAP &&
                  (beats == 2 || beats == 4 || beats == 8 || beats == 16))
            a = base + ((a - base + step) % span);
         else
            a = a + step;
      end
   endfunction

   function automatic void model_write(axi_burst_pkg::addr_t a, axi_burst_pkg::data_t d,
                                       axi_burst_pkg::strb_t s);
      for (int b = 0; b < axi_burst_pkg::STRB_W; b++)
      begin
         if (s[b])
            model[a[9:2]][8*b +: 8] = d[8*b +: 8];
      end
   endfunction

   task automatic write_burst(axi_burst_pkg::id_t id, axi_burst_pkg::addr_t start,
                              axi_burst_pkg::len_t len, axi_burst_pkg::size_t size,
                              axi_burst_pkg::burst_t burst, bit fill);
      axi_burst_pkg::data_t d;
      axi_burst_pkg::strb_t s;
      logic any_err;
      logic done;
      compute_beat_addrs(start, len, size, burst);
      awid    = id;
      awaddr  = start;
      awlen   = len;
      awsize  = size;
      awburst = burst;
      awvalid = 1'b1;
      while (!awready)
         wait_cycle;
      wait_cycle;
      awvalid = 1'b0;
      any_err = 1'b0;
      for (int k = 0; k <= int'(len); k++)
      begin
         d      = fill ? fill_word(beat_addr[k]) : axi_burst_pkg::data_t'($urandom);
         s      = fill ? 4'hF : axi_burst_pkg::strb_t'($urandom);
         wdata  = d;
         wstrb  = s;
         wlast  = (k == int'(len));
         wvalid = 1'b1;
         while (!wready)
            wait_cycle;
         wait_cycle;
         if (in_window(beat_addr[k]))
            model_write(beat_addr[k], d, s);
         else
            any_err = 1'b1;
      end
      wvalid = 1'b0;
      wlast  = 1'b0;
      // random stalls on bready
      do
      begin
         bready = ($urandom % 3) != 0;
         done   = bvalid && bready;
         if (done)
         begin
            check_id("bid", bid, id);
            check_resp("bresp", bresp,
                       any_err ? axi_burst_pkg::RESP_SLVERR : axi_burst_pkg::RESP_OKAY);
         end
         wait_cycle;
      end
      while (!done);
      bready = 1'b0;
   endtask

   task automatic read_burst(axi_burst_pkg::id_t id, axi_burst_pkg::addr_t start,
                             axi_burst_pkg::len_t len, axi_burst_pkg::size_t size,
                             axi_burst_pkg::burst_t burst);
      axi_burst_pkg::addr_t a;
      int k;
      compute_beat_addrs(start, len, size, burst);
      arid    = id;
      araddr  = start;
      arlen   = len;
      arsize  = size;
      arburst = burst;
      arvalid = 1'b1;
      while (!arready)
         wait_cycle;
      wait_cycle;
      arvalid = 1'b0;
      k = 0;
      while (k <= int'(len))
      begin
         rready = ($urandom % 3) != 0;
         if (rvalid && rready)
         begin
            a = beat_addr[k];
            check_data("rdata", rdata, in_window(a) ? model[a[9:2]] : 32'h0);
            check_resp("rresp", rresp,
                       in_window(a) ? axi_burst_pkg::RESP_OKAY : axi_burst_pkg::RESP_SLVERR);
            check_id("rid", rid, id);
            check_last("rlast", rlast, k == int'(len));
            k++;
         end
         wait_cycle;
      end
      rready = 1'b0;
   endtask

   initial
   begin
      axi_burst_pkg::id_t    id;
      axi_burst_pkg::addr_t  a;
      axi_burst_pkg::len_t   len;
      axi_burst_pkg::size_t  size;
      axi_burst_pkg::burst_t burst;
      void'($urandom(SEED));
      ARESETN = 1'b0;
      awid    = '0;
      awaddr  = '0;
      awlen   = '0;
      awsize  = '0;
      awburst = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wlast   = 1'b0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      arid    = '0;
      araddr  = '0;
      arlen   = '0;
      arsize  = '0;
      arburst = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (RESET_CYCLES) @(posedge ACLK);
      #1;
      check_flag("wready in reset", wready, 1'b0);
      check_flag("bvalid in reset", bvalid, 1'b0);
      check_flag("rvalid in reset", rvalid, 1'b0);
      ARESETN = 1'b1;
      wait_cycle;
      check_flag("awready after reset", awready, 1'b1);
      check_flag("arready after reset", arready, 1'b1);
      check_flag("wready after reset", wready, 1'b0);

      // address pattern over the whole window
      for (int f = 0; f < FILL_BURSTS; f++)
         write_burst(4'h0, axi_burst_pkg::addr_t'(f) * 32'h40, 4'd15, 3'd2,
                     axi_burst_pkg::BURST_INCR, 1'b1);

      // each write is read back with the same burst shape
      for (int t = 0; t < TXNS; t++)
      begin
         id = axi_burst_pkg::id_t'($urandom);
         if (t % 2 == 0)
         begin
            a     = axi_burst_pkg::addr_t'($urandom % 1024);
            len   = axi_burst_pkg::len_t'($urandom);
            size  = axi_burst_pkg::size_t'($urandom);
            burst = axi_burst_pkg::burst_t'($urandom);
            write_burst(id, a, len, size, burst, 1'b0);
         end
         else
            read_burst(id, a, len, size, burst);
      end

      $display("run complete: %0d checks, %0d errors", checks, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

/* project.f */
rtl/axi_burst_pkg.sv
rtl/burst_addr_gen.sv
rtl/word_mem.sv
rtl/axi_write_ctrl.sv
rtl/axi_read_ctrl.sv
rtl/axi_burst_slave.sv
bench/axi_burst_slave_assert.sv
bench/tb_axi_burst_slave.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f project.f --top-module tb_axi_burst_slave -o tb_sim
./obj_dir/tb_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "TESTS PASSED" sim.log
then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
